// ==== source/div_pkg.sv ====
// shared definitions for the RV64M iterative divider
// operation codes, width types and the control state encoding

`default_nettype none

package div_pkg;

  // ==================================================
  // widths
  // ==================================================

  typedef logic [63:0] xlen_t;  // operand, result, remainder
  typedef logic [6:0]  cnt_t;   // iteration count 0..64

  // iteration counts per operand width
  localparam cnt_t ITER_DWORD = 7'd64;
  localparam cnt_t ITER_WORD  = 7'd32;

  // ==================================================
  // operation codes
  // ==================================================

  // bit 2 remainder, bit 1 unsigned, bit 0 word form
  typedef logic [2:0] op_t;

  localparam op_t OP_DIV   = 3'b000;
  localparam op_t OP_DIVW  = 3'b001;  // 32-bit signed quotient
  localparam op_t OP_DIVU  = 3'b010;
  localparam op_t OP_DIVUW = 3'b011;
  localparam op_t OP_REM   = 3'b100;
  localparam op_t OP_REMW  = 3'b101;
  localparam op_t OP_REMU  = 3'b110;
  localparam op_t OP_REMUW = 3'b111;

  // ==================================================
  // control FSM
  // ==================================================

  typedef enum logic [1:0] {
    IDLE    = 2'b00,  // waiting for req
    ITERATE = 2'b01,  // core shifting and subtracting
    FIXUP   = 2'b10,  // sign correction into result reg
    ACK     = 2'b11   // result held until req drops
  } div_state_t;

endpackage

`default_nettype wire

// ==== source/div_operand_prep.sv ====
// divider operand preparation
// extends word operands, takes magnitudes and flags divide by zero and overflow

`default_nettype none

module div_operand_prep (
  input  wire div_pkg::op_t   op_i,
  input  wire div_pkg::xlen_t dividend_i,
  input  wire div_pkg::xlen_t divisor_i,
  output div_pkg::xlen_t      dividend_mag_o,
  output div_pkg::xlen_t      divisor_mag_o,
  output logic                neg_quot_o,
  output logic                neg_rem_o,
  output logic                special_o,
  output div_pkg::xlen_t      special_result_o
);

  logic           is_word;
  logic           is_uns;
  logic           is_rem;
  div_pkg::xlen_t dividend_ext;
  div_pkg::xlen_t divisor_ext;
  div_pkg::xlen_t dividend_abs;
  div_pkg::xlen_t divisor_abs;
  div_pkg::xlen_t dividend_res;  // dividend as an architectural result
  div_pkg::xlen_t most_neg;
  logic           dividend_neg;
  logic           divisor_neg;
  logic           div_zero;
  logic           div_ovf;

  assign is_word = op_i[0];
  assign is_uns  = op_i[1];
  assign is_rem  = op_i[2];

  // ==================================================
  // extension and magnitudes
  // ==================================================

  always_comb begin
    if (is_word && is_uns) begin
      dividend_ext = {32'b0, dividend_i[31:0]};
      divisor_ext  = {32'b0, divisor_i[31:0]};
    end else if (is_word) begin
      dividend_ext = {{32{dividend_i[31]}}, dividend_i[31:0]};
      divisor_ext  = {{32{divisor_i[31]}}, divisor_i[31:0]};
    end else begin
      dividend_ext = dividend_i;
      divisor_ext  = divisor_i;
    end
  end

  assign dividend_neg = !is_uns && dividend_ext[63];
  assign divisor_neg  = !is_uns && divisor_ext[63];

  assign dividend_abs = dividend_neg ? (64'd0 - dividend_ext) : dividend_ext;
  assign divisor_abs  = divisor_neg ? (64'd0 - divisor_ext) : divisor_ext;

  // word dividend sits in the upper half so 32 shifts drain it
  assign dividend_mag_o = is_word ? {dividend_abs[31:0], 32'b0} : dividend_abs;
  assign divisor_mag_o  = divisor_abs;

  assign neg_quot_o = dividend_neg ^ divisor_neg;
  assign neg_rem_o  = dividend_neg;  // remainder follows the dividend

  // ==================================================
  // special cases
  // ==================================================

  assign most_neg = is_word ? {{32{1'b1}}, 32'h8000_0000} : {1'b1, 63'b0};

  assign div_zero = (divisor_ext == '0);
  assign div_ovf  = !is_uns && (dividend_ext == most_neg) && (&divisor_ext);

  assign dividend_res = is_word ? {{32{dividend_i[31]}}, dividend_i[31:0]} : dividend_i;

  always_comb begin
    if (div_zero) begin
      special_result_o = is_rem ? dividend_res : {64{1'b1}};
    end else if (div_ovf) begin
      special_result_o = is_rem ? 64'd0 : dividend_res;  // quotient wraps to most-negative
    end else begin
      special_result_o = '0;
    end
  end

  assign special_o = div_zero || div_ovf;

endmodule

`default_nettype wire

// ==== source/div_restoring_core.sv ====
// restoring shift-subtract divider core, one quotient bit per clock
// works on unsigned magnitudes, 32 or 64 iterations

`default_nettype none

module div_restoring_core (
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire                 start_i,
  input  wire                 word_i,
  input  wire div_pkg::xlen_t dividend_i,
  input  wire div_pkg::xlen_t divisor_i,
  output logic                busy_o,
  output div_pkg::xlen_t      quotient_o,
  output div_pkg::xlen_t      remainder_o
);

  div_pkg::cnt_t  cnt_q;      // iterations left
  logic [127:0]   acc_q;      // {partial remainder, dividend / quotient}
  div_pkg::xlen_t divisor_q;
  logic [64:0]    partial;    // 2r plus next dividend bit
  logic [65:0]    diff;       // trial subtraction, bit 65 is the borrow

  // ==================================================
  // trial subtraction
  // ==================================================

  // partial can reach 65 bits when the divisor is above 2^63
  assign partial = acc_q[127:63];
  assign diff    = {1'b0, partial} - {2'b00, divisor_q};

  // ==================================================
  // iteration counter
  // ==================================================

  always_ff @(posedge clk) begin
    if (rst_n) begin
      cnt_q <= '0;
    end else if (start_i) begin
      cnt_q <= word_i ? div_pkg::ITER_WORD : div_pkg::ITER_DWORD;
    end else if (busy_o) begin
      cnt_q <= cnt_q - 7'd1;
    end
  end

  assign busy_o = (cnt_q != '0);

  // ==================================================
  // remainder / quotient register
  // ==================================================

  always_ff @(posedge clk) begin
    if (start_i) begin
      acc_q     <= {64'b0, dividend_i};
      divisor_q <= divisor_i;
    end else if (busy_o) begin
      if (diff[65]) begin
        acc_q <= {acc_q[126:0], 1'b0};                 // restore, quotient bit 0
      end else begin
        acc_q <= {diff[63:0], acc_q[62:0], 1'b1};      // keep difference
      end
    end
  end

  // quotient bits enter at the bottom, word forms end up in [31:0]
  assign quotient_o  = acc_q[63:0];
  assign remainder_o = acc_q[127:64];

endmodule

`default_nettype wire

// ==== source/div_result_fixup.sv ====
// divider result fix-up
// applies signs, picks quotient or remainder and holds the final result

`default_nettype none

module div_result_fixup (
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire                 start_i,
  input  wire div_pkg::op_t   op_i,
  input  wire                 neg_quot_i,
  input  wire                 neg_rem_i,
  input  wire                 capture_i,
  input  wire                 load_special_i,
  input  wire div_pkg::xlen_t special_result_i,
  input  wire div_pkg::xlen_t quotient_i,
  input  wire div_pkg::xlen_t remainder_i,
  output div_pkg::xlen_t      result_o
);

  div_pkg::op_t   op_q;
  logic           neg_quot_q;
  logic           neg_rem_q;
  div_pkg::xlen_t quot_signed;
  div_pkg::xlen_t rem_signed;
  div_pkg::xlen_t result_d;

  // operation context for the division in flight
  always_ff @(posedge clk) begin
    if (start_i) begin
      op_q       <= op_i;
      neg_quot_q <= neg_quot_i;
      neg_rem_q  <= neg_rem_i;
    end
  end

  assign quot_signed = neg_quot_q ? (64'd0 - quotient_i) : quotient_i;
  assign rem_signed  = neg_rem_q ? (64'd0 - remainder_i) : remainder_i;

  always_comb begin
    unique case (op_q)
      div_pkg::OP_DIV, div_pkg::OP_DIVU:   result_d = quot_signed;
      div_pkg::OP_DIVW, div_pkg::OP_DIVUW: result_d = {{32{quot_signed[31]}}, quot_signed[31:0]};
      div_pkg::OP_REM, div_pkg::OP_REMU:   result_d = rem_signed;
      div_pkg::OP_REMW, div_pkg::OP_REMUW: result_d = {{32{rem_signed[31]}}, rem_signed[31:0]};
    endcase
  end

  // result register, held through the acknowledge phase
  always_ff @(posedge clk) begin
    if (rst_n) begin
      result_o <= '0;
    end else if (load_special_i) begin
      result_o <= special_result_i;  // already final
    end else if (capture_i) begin
      result_o <= result_d;
    end
  end

endmodule

`default_nettype wire

// ==== source/div_control.sv ====
// divider sequencing FSM with a four-phase req/ack handshake
// starts the core or loads a fixed result, then holds ack until req drops

`default_nettype none

module div_control (
  input  wire  clk,
  input  wire  rst_n,
  input  wire  req_i,
  input  wire  special_i,
  input  wire  busy_i,
  output logic start_o,
  output logic capture_o,
  output logic load_special_o,
  output logic ack_o
);

  div_pkg::div_state_t state_q;
  div_pkg::div_state_t state_d;

  // ==================================================
  // next state
  // ==================================================

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      div_pkg::IDLE: begin
        if (req_i) begin
          state_d = special_i ? div_pkg::ACK : div_pkg::ITERATE;
        end
      end
      div_pkg::ITERATE: begin
        if (!busy_i) begin
          state_d = div_pkg::FIXUP;
        end
      end
      div_pkg::FIXUP: begin
        state_d = div_pkg::ACK;  // one cycle for sign correction
      end
      div_pkg::ACK: begin
        if (!req_i) begin
          state_d = div_pkg::IDLE;
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q <= div_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ==================================================
  // outputs
  // ==================================================

  assign start_o        = (state_q == div_pkg::IDLE) && req_i && !special_i;
  assign load_special_o = (state_q == div_pkg::IDLE) && req_i && special_i;
  assign capture_o      = (state_q == div_pkg::FIXUP);
  assign ack_o          = (state_q == div_pkg::ACK);  // result_o valid and stable

endmodule

`default_nettype wire

// ==== source/div_unit_top.sv ====
// RV64M iterative divider top level
// operand prep, restoring core, result fix-up and handshake control

`default_nettype none

module div_unit_top (
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire                 req_i,
  input  wire div_pkg::op_t   op_i,
  input  wire div_pkg::xlen_t dividend_i,
  input  wire div_pkg::xlen_t divisor_i,
  output logic                ack_o,
  output div_pkg::xlen_t      result_o
);

  div_pkg::xlen_t dividend_mag;
  div_pkg::xlen_t divisor_mag;
  div_pkg::xlen_t special_result;
  div_pkg::xlen_t quotient;
  div_pkg::xlen_t remainder;
  logic           neg_quot;
  logic           neg_rem;
  logic           special;
  logic           start;
  logic           capture;
  logic           load_special;
  logic           busy;

  div_operand_prep i_prep (
    .op_i             (op_i),
    .dividend_i       (dividend_i),
    .divisor_i        (divisor_i),
    .dividend_mag_o   (dividend_mag),
    .divisor_mag_o    (divisor_mag),
    .neg_quot_o       (neg_quot),
    .neg_rem_o        (neg_rem),
    .special_o        (special),
    .special_result_o (special_result)
  );

  div_restoring_core i_core (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (start),
    .word_i      (op_i[0]),  // word form bit
    .dividend_i  (dividend_mag),
    .divisor_i   (divisor_mag),
    .busy_o      (busy),
    .quotient_o  (quotient),
    .remainder_o (remainder)
  );

  div_result_fixup i_fixup (
    .clk              (clk),
    .rst_n            (rst_n),
    .start_i          (start),
    .op_i             (op_i),
    .neg_quot_i       (neg_quot),
    .neg_rem_i        (neg_rem),
    .capture_i        (capture),
    .load_special_i   (load_special),
    .special_result_i (special_result),
    .quotient_i       (quotient),
    .remainder_i      (remainder),
    .result_o         (result_o)
  );

  div_control i_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i),
    .special_i      (special),
    .busy_i         (busy),
    .start_o        (start),
    .capture_o      (capture),
    .load_special_o (load_special),
    .ack_o          (ack_o)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_div_unit.sv ====
// testbench for the RV64M iterative divider
// golden vectors from a data file, then random unsigned and word operands

`default_nettype none

module tb_div_unit;

  localparam int TIMEOUT_CYCLES = 200;  // longest operation is 66 cycles
  localparam int RAND_COUNT     = 40;
  localparam     GOLDEN_FILE    = "testbench/div_golden.txt";

  logic           clk;
  logic           rst_n;
  logic           req_i;
  div_pkg::op_t   op_i;
  div_pkg::xlen_t dividend_i;
  div_pkg::xlen_t divisor_i;
  logic           ack_o;
  div_pkg::xlen_t result_o;

  integer         seed;
  integer         errors;
  integer         checks;
  integer         golden_count;
  logic           timed_out;
  integer         fd;
  integer         code;
  integer         got;
  integer         idx;
  integer         pick;
  integer         shift;
  logic           file_done;
  reg [1023:0]    skip_line;  // comment lines of the golden file
  div_pkg::op_t   g_op;
  div_pkg::xlen_t g_a;
  div_pkg::xlen_t g_b;
  div_pkg::xlen_t g_exp;
  div_pkg::op_t   rand_ops [0:3];

  div_unit_top i_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_i      (req_i),
    .op_i       (op_i),
    .dividend_i (dividend_i),
    .divisor_i  (divisor_i),
    .ack_o      (ack_o),
    .result_o   (result_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ==================================================
  // reference for the random operands
  // ==================================================

  function automatic div_pkg::xlen_t expected_unsigned(input div_pkg::op_t op,
                                                       input div_pkg::xlen_t a,
                                                       input div_pkg::xlen_t b);
    logic [31:0] word_res;
    word_res = '0;
    case (op)
      div_pkg::OP_DIVU: expected_unsigned = a / b;
      div_pkg::OP_REMU: expected_unsigned = a % b;
      div_pkg::OP_DIVUW: begin
        word_res = a[31:0] / b[31:0];
        expected_unsigned = {{32{word_res[31]}}, word_res};  // 32-bit result sign-extended
      end
      div_pkg::OP_REMUW: begin
        word_res = a[31:0] % b[31:0];
        expected_unsigned = {{32{word_res[31]}}, word_res};
      end
      default: expected_unsigned = '0;
    endcase
  endfunction

  // ==================================================
  // one four-phase transaction
  // ==================================================

  task automatic run_op(input div_pkg::op_t op, input div_pkg::xlen_t a,
                        input div_pkg::xlen_t b, input div_pkg::xlen_t exp_res);
    integer         cnt;
    integer         hold;
    @(negedge clk);
    op_i       = op;
    dividend_i = a;
    divisor_i  = b;
    req_i      = 1'b1;
    cnt = 0;
    while (!ack_o && cnt < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cnt = cnt + 1;
    end
    if (!ack_o) begin
      $display("timeout: ack_o never rose for op %0d within %0d cycles", op, TIMEOUT_CYCLES);
      errors    = errors + 1;
      timed_out = 1'b1;
      req_i     = 1'b0;
      return;
    end
    checks = checks + 1;
    if (result_o !== exp_res) begin
      $display("Fail result_o op=%0d dividend=%h divisor=%h: expected %h, got %h",
               op, a, b, exp_res, result_o);
      errors = errors + 1;
    end
    // result must not move while the requester keeps req high
    hold = $unsigned($random(seed)) % 6;
    repeat (hold) begin
      @(negedge clk);
      checks = checks + 1;
      if (ack_o !== 1'b1) begin
        $display("Fail ack_o while req_i held: expected 1, got %h", ack_o);
        errors = errors + 1;
      end
      if (result_o !== exp_res) begin
        $display("Fail result_o while req_i held: expected %h, got %h", exp_res, result_o);
        errors = errors + 1;
      end
    end
    req_i = 1'b0;
    cnt = 0;
    while (ack_o && cnt < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cnt = cnt + 1;
    end
    checks = checks + 1;
    if (ack_o) begin
      $display("timeout: ack_o stayed high for %0d cycles after req_i dropped", TIMEOUT_CYCLES);
      errors    = errors + 1;
      timed_out = 1'b1;
    end else if (cnt != 1) begin
      $display("ack_o fell %0d cycles after req_i dropped instead of 1", cnt);
      errors = errors + 1;
    end
  endtask

  // ==================================================
  // main sequence
  // ==================================================

  initial begin
    seed         = 32'hfdea_699b;
    errors       = 0;
    checks       = 0;
    golden_count = 0;
    timed_out    = 1'b0;
    rst_n        = 1'b1;  // reset is active high
    req_i        = 1'b0;
    op_i         = div_pkg::OP_DIV;
    dividend_i   = '0;
    divisor_i    = '0;
    rand_ops[0]  = div_pkg::OP_DIVU;
    rand_ops[1]  = div_pkg::OP_REMU;
    rand_ops[2]  = div_pkg::OP_DIVUW;
    rand_ops[3]  = div_pkg::OP_REMUW;

    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b0;

    checks = checks + 2;
    if (ack_o !== 1'b0) begin
      $display("Fail ack_o after reset: expected 0, got %h", ack_o);
      errors = errors + 1;
    end
    if (result_o !== '0) begin
      $display("Fail result_o after reset: expected %h, got %h", 64'd0, result_o);
      errors = errors + 1;
    end

    fd = $fopen(GOLDEN_FILE, "r");
    if (fd == 0) begin
      $display("could not open the golden file %s", GOLDEN_FILE);
      errors = errors + 1;
    end else begin
      file_done = 1'b0;
      while (!file_done && !timed_out) begin
        code = $fscanf(fd, "%h %h %h %h\n", g_op, g_a, g_b, g_exp);
        if (code == 4) begin
          golden_count = golden_count + 1;
          run_op(g_op, g_a, g_b, g_exp);
        end else begin
          got = $fgets(skip_line, fd);  // skip a comment line
          if (got == 0) begin
            file_done = 1'b1;
          end
        end
        if ($feof(fd)) begin
          file_done = 1'b1;
        end
      end
      $fclose(fd);
      if (golden_count == 0) begin
        $display("no vectors were read from the golden file");
        errors = errors + 1;
      end
    end

    for (idx = 0; idx < RAND_COUNT && !timed_out; idx = idx + 1) begin
      pick  = $unsigned($random(seed)) % 4;
      shift = $unsigned($random(seed)) % 64;  // spread divisor sizes
      g_op  = rand_ops[pick];
      g_a[63:32] = $random(seed);
      g_a[31:0]  = $random(seed);
      g_b[63:32] = $random(seed);
      g_b[31:0]  = $random(seed);
      g_b = g_b >> shift;
      if (g_b[31:0] == 32'd0) begin
        g_b[0] = 1'b1;  // keep the divisor nonzero for word forms too
      end
      run_op(g_op, g_a, g_b, expected_unsigned(g_op, g_a, g_b));
    end

    $display("golden vectors: %0d, checks: %0d, errors: %0d", golden_count, checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/div_golden.txt ====
// columns: op dividend divisor expected, all hex
// op bit 2 remainder, bit 1 unsigned, bit 0 word form
0 0000000000000064 0000000000000007 000000000000000e
0 ffffffffffffff9c 0000000000000007 fffffffffffffff2
0 0000000000000064 fffffffffffffff9 fffffffffffffff2
4 ffffffffffffff9c 0000000000000007 fffffffffffffffe
4 0000000000000064 fffffffffffffff9 0000000000000002
4 ffffffffffffff9c fffffffffffffff9 fffffffffffffffe
0 8000000000000000 0000000000000003 d555555555555556
4 8000000000000000 0000000000000003 fffffffffffffffe
2 ffffffffffffffff 0000000000000003 5555555555555555
2 ffffffffffffffff 8000000000000000 0000000000000001
6 ffffffffffffffff 8000000000000000 7fffffffffffffff
2 8000000000000000 ffffffffffffffff 0000000000000000
6 8000000000000000 ffffffffffffffff 8000000000000000
0 0000000000001234 0000000000000000 ffffffffffffffff
4 ffffffffffffff9c 0000000000000000 ffffffffffffff9c
6 fedcba9876543210 0000000000000000 fedcba9876543210
0 8000000000000000 ffffffffffffffff 8000000000000000
4 8000000000000000 ffffffffffffffff 0000000000000000
1 deadbeefffffff9c 1234567800000007 fffffffffffffff2
5 deadbeefffffff9c 1234567800000007 fffffffffffffffe
1 ffff000000000007 0000fffffffffffe fffffffffffffffd
5 ffff000000000007 0000fffffffffffe 0000000000000001
3 aaaaaaaaffffffff 5555555500000003 0000000055555555
3 00000000ffffffff 1234000000000001 ffffffffffffffff
7 1111111180000005 ffffffff80000000 0000000000000005
7 00000000fffffffe 00000000ffffffff fffffffffffffffe
1 ffffffff00000010 1234567800000000 ffffffffffffffff
5 0000000180000000 abcd000000000000 ffffffff80000000
7 0000000080000001 0000000100000000 ffffffff80000001
1 1234567880000000 00000000ffffffff ffffffff80000000
5 1234567880000000 00000000ffffffff 0000000000000000

// ==== sources.f ====
source/div_pkg.sv
source/div_operand_prep.sv
source/div_restoring_core.sv
source/div_result_fixup.sv
source/div_control.sv
source/div_unit_top.sv
testbench/tb_div_unit.sv

// ==== Bender.yml ====
package:
  name: div_unit

sources:
  - source/div_pkg.sv
  - source/div_operand_prep.sv
  - source/div_restoring_core.sv
  - source/div_result_fixup.sv
  - source/div_control.sv
  - source/div_unit_top.sv
  - target: test
    files:
      - testbench/tb_div_unit.sv
